//--- source/aluExecute.sv
// --------------------------------------
// Execute stage. Forwards from its own
// output register, checks the condition
// against NZCV, runs the ALU and holds the
// flags. Only instructions that pass
// their condition raise resValid.
// --------------------------------------
`timescale 1ns/1ns

module aluExecute
(
   input  logic                                clk,
   input  logic                                reset,
   stageOperandIf.executeSide                  operands,
   output logic                                resValid,
   output logic [armCorePkg::regAddrWidth-1:0] resRd,
   output logic [armCorePkg::dataWidth-1:0]    resData,
   output logic [3:0]                          flags
);
   import armCorePkg::*;

   logic [dataWidth-1:0] srcA;
   logic [dataWidth-1:0] srcB;
   logic [dataWidth-1:0] bInput;
   logic [dataWidth:0]   sum;
   logic [dataWidth-1:0] aluResult;
   logic                 subtract;
   logic                 arithOp;
   logic                 carryOut;
   logic                 overflow;
   logic                 signedGe;
   logic                 condPass;
   logic                 flagWrite;
   logic [3:0]           flagsNext;

   // Instruction one ahead still sits in resData
   assign srcA = (resValid && resRd == operands.rnAddr) ? resData : operands.rnData;
   assign srcB = (resValid && operands.usesRm && resRd == operands.rmAddr) ?
                 resData : operands.op2Data;

   // SUB as A + ~B + 1, so carry set means no borrow
   assign subtract = (operands.aluOp == aluSub);
   assign arithOp  = (operands.aluOp == aluAdd) || subtract;
   assign bInput   = subtract ? ~srcB : srcB;
   assign sum      = {1'b0, srcA} + {1'b0, bInput} + {{dataWidth{1'b0}}, subtract};
   assign carryOut = sum[dataWidth];
   assign overflow = ~(srcA[dataWidth-1] ^ bInput[dataWidth-1]) &
                     (srcA[dataWidth-1] ^ sum[dataWidth-1]);

   always_comb
   begin
      case (operands.aluOp)
         aluAnd:  aluResult = srcA & srcB;
         aluOrr:  aluResult = srcA | srcB;
         default: aluResult = sum[dataWidth-1:0];   // ADD or SUB
      endcase
   end

   assign signedGe = (flags[flagN] == flags[flagV]);

   always_comb
   begin
      case (operands.cond)
         condEq:  condPass = flags[flagZ];
         condNe:  condPass = ~flags[flagZ];
         condCs:  condPass = flags[flagC];
         condCc:  condPass = ~flags[flagC];
         condMi:  condPass = flags[flagN];
         condPl:  condPass = ~flags[flagN];
         condVs:  condPass = flags[flagV];
         condVc:  condPass = ~flags[flagV];
         condHi:  condPass = flags[flagC] & ~flags[flagZ];
         condLs:  condPass = ~flags[flagC] | flags[flagZ];
         condGe:  condPass = signedGe;
         condLt:  condPass = ~signedGe;
         condGt:  condPass = ~flags[flagZ] & signedGe;
         condLe:  condPass = flags[flagZ] | ~signedGe;
         condAl:  condPass = 1'b1;
         default: condPass = 1'b0;   // 1111
      endcase
   end

   assign flagWrite = operands.valid & condPass & operands.setFlags;

   always_comb
   begin
      flagsNext = flags;
      if (flagWrite)
      begin
         flagsNext[flagN] = aluResult[dataWidth-1];
         flagsNext[flagZ] = (aluResult == '0);
         if (arithOp)
         begin
            flagsNext[flagC] = carryOut;
            flagsNext[flagV] = overflow;
         end
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags    <= 4'b0000;
         resValid <= 1'b0;
      end
      else
      begin
         flags    <= flagsNext;
         resValid <= operands.valid & condPass;
      end
   end

   always_ff @(posedge clk)
   begin
      resRd   <= operands.rd;
      resData <= aluResult;
   end

endmodule

//--- source/armCorePkg.sv
// --------------------------------------
// Shared widths, encodings and types for the
// three-stage ARM data-processing core.
// Imported by the decode, execute and top
// level modules and by the interface.
// --------------------------------------
package armCorePkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;
   localparam int numRegs      = 16;

   // Instruction bits 27:26
   localparam logic [1:0] opDataProc = 2'b00;

   // Opcode, instruction bits 24:21
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functOrr = 4'b1100;

   // Operation select passed from decode to execute
   localparam logic [1:0] aluAdd = 2'b00;
   localparam logic [1:0] aluSub = 2'b01;
   localparam logic [1:0] aluAnd = 2'b10;
   localparam logic [1:0] aluOrr = 2'b11;

   // Condition field, bits 31:28; 1111 never executes
   localparam logic [3:0] condEq = 4'b0000;
   localparam logic [3:0] condNe = 4'b0001;
   localparam logic [3:0] condCs = 4'b0010;
   localparam logic [3:0] condCc = 4'b0011;
   localparam logic [3:0] condMi = 4'b0100;
   localparam logic [3:0] condPl = 4'b0101;
   localparam logic [3:0] condVs = 4'b0110;
   localparam logic [3:0] condVc = 4'b0111;
   localparam logic [3:0] condHi = 4'b1000;
   localparam logic [3:0] condLs = 4'b1001;
   localparam logic [3:0] condGe = 4'b1010;
   localparam logic [3:0] condLt = 4'b1011;
   localparam logic [3:0] condGt = 4'b1100;
   localparam logic [3:0] condLe = 4'b1101;
   localparam logic [3:0] condAl = 4'b1110;

   // Bit positions in the NZCV word
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

   // Operand 2 field, instruction bits 11:0
   typedef union packed {
      struct packed {
         logic [3:0] rotate;  // Rotate right by twice this
         logic [7:0] imm8;
      } immView;
      struct packed {
         logic [7:0] shift;   // Shifter not implemented
         logic [3:0] rm;
      } regView;
   } operand2_u;

endpackage

//--- source/armDpCore.sv
// --------------------------------------
// Top level of the pipelined ARM
// data-processing core. One instruction
// per instrValid strobe; its result shows
// on the result ports two edges later.
// --------------------------------------
`timescale 1ns/1ns

module armDpCore
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                instrValid,
   input  logic [armCorePkg::dataWidth-1:0]    instr,
   output logic                                resultValid,
   output logic [armCorePkg::regAddrWidth-1:0] resultReg,
   output logic [armCorePkg::dataWidth-1:0]    resultData,
   output logic [3:0]                          flags
);
   import armCorePkg::*;

   logic [regAddrWidth-1:0] readAddrA;
   logic [regAddrWidth-1:0] readAddrB;
   logic [dataWidth-1:0]    readDataA;
   logic [dataWidth-1:0]    readDataB;
   logic                    writeEnable;
   logic [regAddrWidth-1:0] writeAddr;
   logic [dataWidth-1:0]    writeData;
   logic                    resValid;
   logic [regAddrWidth-1:0] resRd;
   logic [dataWidth-1:0]    resData;

   stageOperandIf stageBus ();

   registerFile regs (.clk(clk), .writeEnable(writeEnable), .writeAddr(writeAddr),
                      .readAddrA(readAddrA), .readAddrB(readAddrB),
                      .writeData(writeData), .readDataA(readDataA),
                      .readDataB(readDataB));

   instrDecode decode (.clk(clk), .reset(reset), .instrValid(instrValid),
                       .instr(instr), .readAddrA(readAddrA), .readAddrB(readAddrB),
                       .readDataA(readDataA), .readDataB(readDataB),
                       .operands(stageBus.decodeSide));

   aluExecute execute (.clk(clk), .reset(reset), .operands(stageBus.executeSide),
                       .resValid(resValid), .resRd(resRd), .resData(resData),
                       .flags(flags));

   resultWriteback writeback (.clk(clk), .reset(reset), .resValid(resValid),
                              .resRd(resRd), .resData(resData),
                              .writeEnable(writeEnable), .writeAddr(writeAddr),
                              .writeData(writeData), .resultValid(resultValid),
                              .resultReg(resultReg), .resultData(resultData));

endmodule

//--- source/instrDecode.sv
// --------------------------------------
// Decode stage. Splits the instruction,
// reads Rn and Rm, builds operand 2 and
// maps the opcode to an ALU operation.
// Anything outside ADD/SUB/AND/ORR is
// passed on with valid low.
// --------------------------------------
`timescale 1ns/1ns

module instrDecode
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                instrValid,
   input  logic [armCorePkg::dataWidth-1:0]    instr,
   output logic [armCorePkg::regAddrWidth-1:0] readAddrA,
   output logic [armCorePkg::regAddrWidth-1:0] readAddrB,
   input  logic [armCorePkg::dataWidth-1:0]    readDataA,
   input  logic [armCorePkg::dataWidth-1:0]    readDataB,
   stageOperandIf.decodeSide                   operands
);
   import armCorePkg::*;

   logic [3:0]              cond;
   logic [1:0]              opField;
   logic                    immForm;
   logic [3:0]              funct;
   logic                    sBit;
   logic [regAddrWidth-1:0] rnAddr;
   logic [regAddrWidth-1:0] rdAddr;
   operand2_u               op2Field;
   logic [dataWidth-1:0]    immExt;
   logic [2*dataWidth-1:0]  immPair;
   logic [dataWidth-1:0]    op2Value;
   logic [1:0]              aluOp;
   logic                    knownOp;
   logic                    decodedValid;

   assign {cond, opField, immForm, funct, sBit, rnAddr, rdAddr, op2Field} = instr;

   assign readAddrA = rnAddr;
   assign readAddrB = op2Field.regView.rm;

   // Rotate right of imm8 by 2*rotate, done on a doubled copy
   assign immExt   = {{(dataWidth-8){1'b0}}, op2Field.immView.imm8};
   assign immPair  = {immExt, immExt} >> {op2Field.immView.rotate, 1'b0};
   assign op2Value = immForm ? immPair[dataWidth-1:0] : readDataB;

   always_comb
   begin
      knownOp = 1'b1;
      case (funct)
         functAdd: aluOp = aluAdd;
         functSub: aluOp = aluSub;
         functAnd: aluOp = aluAnd;
         functOrr: aluOp = aluOrr;
         default:
         begin
            aluOp   = aluAdd;
            knownOp = 1'b0;    // Treated as a no-op
         end
      endcase
   end

   assign decodedValid = instrValid & (opField == opDataProc) & knownOp;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         operands.valid <= 1'b0;
      else
         operands.valid <= decodedValid;
   end

   always_ff @(posedge clk)
   begin
      operands.cond     <= cond;
      operands.aluOp    <= aluOp;
      operands.setFlags <= sBit;
      operands.rd       <= rdAddr;
      operands.rnAddr   <= rnAddr;
      operands.rmAddr   <= op2Field.regView.rm;
      operands.usesRm   <= ~immForm;
      operands.rnData   <= readDataA;
      operands.op2Data  <= op2Value;
   end

endmodule

//--- source/registerFile.sv
// --------------------------------------
// Sixteen general registers, two
// combinational read ports and one write
// port. A read of the register being
// written returns the new value.
// --------------------------------------
`timescale 1ns/1ns

module registerFile
(
   input  logic                                clk,
   input  logic                                writeEnable,
   input  logic [armCorePkg::regAddrWidth-1:0] writeAddr,
   input  logic [armCorePkg::regAddrWidth-1:0] readAddrA,
   input  logic [armCorePkg::regAddrWidth-1:0] readAddrB,
   input  logic [armCorePkg::dataWidth-1:0]    writeData,
   output logic [armCorePkg::dataWidth-1:0]    readDataA,
   output logic [armCorePkg::dataWidth-1:0]    readDataB
);

   logic [$bits(writeData)-1:0] regs [2**$bits(writeAddr)];

   always_ff @(posedge clk)
   begin
      if (writeEnable)
         regs[writeAddr] <= writeData;
   end

   // Write-through covers the instruction two ahead
   assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
   assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- source/resultWriteback.sv
// --------------------------------------
// Result stage. Writes the executed result
// into the register file and presents it
// on the result ports for one cycle.
// --------------------------------------
`timescale 1ns/1ns

module resultWriteback
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                resValid,
   input  logic [armCorePkg::regAddrWidth-1:0] resRd,
   input  logic [armCorePkg::dataWidth-1:0]    resData,
   output logic                                writeEnable,
   output logic [armCorePkg::regAddrWidth-1:0] writeAddr,
   output logic [armCorePkg::dataWidth-1:0]    writeData,
   output logic                                resultValid,
   output logic [armCorePkg::regAddrWidth-1:0] resultReg,
   output logic [armCorePkg::dataWidth-1:0]    resultData
);

   // Register file write lands on the same edge as the outputs
   assign writeEnable = resValid;
   assign writeAddr   = resRd;
   assign writeData   = resData;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         resultValid <= 1'b0;
      else
         resultValid <= resValid;
   end

   always_ff @(posedge clk)
   begin
      resultReg  <= resRd;
      resultData <= resData;
   end

endmodule

//--- source/stageOperandIf.sv
// --------------------------------------
// One decoded instruction on its way from
// the decode stage to the execute stage.
// Decode drives every signal from flops.
// --------------------------------------
`timescale 1ns/1ns

interface stageOperandIf;
   import armCorePkg::*;

   logic                    valid;
   logic [3:0]              cond;
   logic [1:0]              aluOp;
   logic                    setFlags;
   logic [regAddrWidth-1:0] rd;
   logic [regAddrWidth-1:0] rnAddr;
   logic [regAddrWidth-1:0] rmAddr;
   logic                    usesRm;   // Low for the immediate form
   logic [dataWidth-1:0]    rnData;
   logic [dataWidth-1:0]    op2Data;  // Rotated immediate or Rm value

   modport decodeSide (output valid, cond, aluOp, setFlags, rd, rnAddr, rmAddr,
                       usesRm, rnData, op2Data);
   modport executeSide (input valid, cond, aluOp, setFlags, rd, rnAddr, rmAddr,
                        usesRm, rnData, op2Data);

endinterface

//--- tb.f
source/armCorePkg.sv
source/stageOperandIf.sv
source/registerFile.sv
source/instrDecode.sv
source/aluExecute.sv
source/resultWriteback.sv
source/armDpCore.sv
testbench/tbArmDpCore.sv

//--- testbench/tbArmDpCore.sv
// ----------------------------------------
// Directed testbench for the pipelined ARM
// data-processing core. A reference model
// predicts each result and the NZCV flags,
// and a monitor checks every result slot.
// ----------------------------------------
`timescale 1ns/1ns

module tbArmDpCore;
   import armCorePkg::*;

   logic        clk;
   logic        reset;
   logic        instrValid;
   logic [31:0] instr;
   logic        resultValid;
   logic [3:0]  resultReg;
   logic [31:0] resultData;
   logic [3:0]  flags;

   logic [31:0] modelRegs [16];   // Unknown until first written
   logic [3:0]  modelFlags;
   logic [36:0] expectQ [$];      // Strobe, register, data
   int          dueQ [$];         // Cycle in which each slot shows
   logic [36:0] expected;
   int          cycleCount;
   int          issued;
   int          valueErrors;
   int          strayStrobes;
   logic [15:0] lfsrState;

   armDpCore DUT (.clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
                  .resultValid(resultValid), .resultReg(resultReg),
                  .resultData(resultData), .flags(flags));

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
      cycleCount <= cycleCount + 1;

   function automatic logic [31:0] randomBits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 16'hB400 : lfsrState >> 1;
         value = {value[30:0], lfsrState[0]};
      end
      return value;
   endfunction

   function automatic logic [31:0] dp(logic [3:0] cond, logic immForm, logic [3:0] opcode,
                                      logic setFlags, logic [3:0] rn, logic [3:0] rd,
                                      logic [11:0] op2);
      return {cond, opDataProc, immForm, opcode, setFlags, rn, rd, op2};
   endfunction

   function automatic logic [31:0] rotateImm(logic [7:0] imm8, logic [3:0] rot);
      logic [31:0] value;
      value = {24'd0, imm8};
      for (int i = 0; i < 2 * rot; i++)
         value = {value[0], value[31:1]};   // One bit right per step
      return value;
   endfunction

   // Odd codes invert the even code below them; 1111 never passes
   function automatic logic condHolds(logic [3:0] cond, logic [3:0] f);
      logic n, z, c, v, base;
      {n, z, c, v} = f;
      case (cond[3:1])
         3'd0:    base = z;
         3'd1:    base = c;
         3'd2:    base = n;
         3'd3:    base = v;
         3'd4:    base = c & ~z;
         3'd5:    base = (n == v);
         3'd6:    base = ~z & (n == v);
         default: base = 1'b1;
      endcase
      return cond[0] ? ~base : base;
   endfunction

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] want);
      if (got !== want)
      begin
         valueErrors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic modelIssue(input logic [31:0] ins);
      logic [31:0] a, b, res;
      logic [32:0] wide;
      logic [3:0]  opcode, f;
      logic        known, pass;
      opcode = ins[24:21];
      a = modelRegs[ins[19:16]];
      b = ins[25] ? rotateImm(ins[7:0], ins[11:8]) : modelRegs[ins[3:0]];
      known = (ins[27:26] == opDataProc) && (opcode == functAdd || opcode == functSub ||
              opcode == functAnd || opcode == functOrr);
      pass = known && condHolds(ins[31:28], modelFlags);
      f = modelFlags;
      case (opcode)
         functAdd:
         begin
            wide = {1'b0, a} + {1'b0, b};
            res = wide[31:0];
            f[flagC] = wide[32];
            f[flagV] = (a[31] == b[31]) && (res[31] != a[31]);
         end
         functSub:
         begin
            res = a - b;
            f[flagC] = (a >= b);   // No borrow
            f[flagV] = (a[31] != b[31]) && (res[31] != a[31]);
         end
         functAnd: res = a & b;
         default:  res = a | b;
      endcase
      f[flagN] = res[31];
      f[flagZ] = (res == 32'd0);
      if (pass)
      begin
         modelRegs[ins[15:12]] = res;
         if (ins[20])
            modelFlags = f;
      end
      expectQ.push_back({pass, ins[15:12], res});
      dueQ.push_back(cycleCount + 3);
   endtask

   task automatic issue(input logic [31:0] ins);
      @(posedge clk);
      #1;
      instrValid = 1'b1;
      instr = ins;
      issued++;
      modelIssue(ins);
   endtask

   // Stop issuing, wait for every slot to retire, then compare flags
   task automatic drain();
      @(posedge clk);
      #1;
      instrValid = 1'b0;
      while (dueQ.size() > 0)
         @(posedge clk);
      #1;
      checkValue("flags", {28'd0, flags}, {28'd0, modelFlags});
   endtask

   task automatic setReg(input logic [3:0] rd, input logic [7:0] imm8, input logic [3:0] rot);
      issue(dp(condAl, 1'b1, functAnd, 1'b0, rd, rd, 12'h000));
      issue(dp(condAl, 1'b1, functAdd, 1'b0, rd, rd, {rot, imm8}));
   endtask

   always @(negedge clk)
   begin
      if (dueQ.size() > 0 && dueQ[0] == cycleCount)
      begin
         expected = expectQ[0];
         expectQ.delete(0);
         dueQ.delete(0);
         checkValue("resultValid", {31'd0, resultValid}, {31'd0, expected[36]});
         if (expected[36])
         begin
            checkValue("resultReg", {28'd0, resultReg}, {28'd0, expected[35:32]});
            checkValue("resultData", resultData, expected[31:0]);
         end
      end
      else if (resultValid !== 1'b0 && !reset)
      begin
         strayStrobes++;
         $display("Result strobe at time %0t with no instruction due", $time);
      end
   end

   task automatic idleAfterReset();
      repeat (5)
      begin
         @(negedge clk);
         checkValue("idle resultValid", {31'd0, resultValid}, 32'd0);
         checkValue("idle flags", {28'd0, flags}, 32'd0);
      end
   endtask

   task automatic loadRegisters();
      for (int r = 0; r < 16; r++)
         setReg(4'(r), 8'(8'h35 + r * 13), 4'(r));   // Every rotate value once
      drain();
   endtask

   task automatic forwardChain();
      repeat (2)
      begin
         issue(dp(condAl, 1'b0, functAdd, 1'b0, 4'd1, 4'd7, 12'h002));
         issue(dp(condAl, 1'b0, functSub, 1'b0, 4'd7, 4'd8, 12'h003));  // One ahead
         issue(dp(condAl, 1'b0, functAnd, 1'b0, 4'd8, 4'd9, 12'h007));  // One and two ahead
         issue(dp(condAl, 1'b0, functOrr, 1'b0, 4'd9, 4'd10, 12'h008));
         issue(dp(condAl, 1'b0, functAdd, 1'b0, 4'd9, 4'd11, 12'h00A)); // Two ahead
         issue(dp(condAl, 1'b0, functSub, 1'b0, 4'd11, 4'd1, 12'h00B));
      end
      drain();
   endtask

   task automatic flagCases();
      setReg(4'd1, 8'h01, 4'h0);
      setReg(4'd2, 8'h02, 4'h0);
      setReg(4'd3, 8'h02, 4'h1);   // 0x80000000
      setReg(4'd4, 8'h7F, 4'h4);   // 0x7F000000
      issue(dp(condAl, 1'b0, functSub, 1'b1, 4'd1, 4'd8, 12'h001));  // Zero
      drain();
      issue(dp(condAl, 1'b0, functSub, 1'b1, 4'd1, 4'd8, 12'h002));  // Negative, borrow
      drain();
      issue(dp(condAl, 1'b0, functAdd, 1'b1, 4'd4, 4'd8, 12'h004));  // Signed overflow
      drain();
      issue(dp(condAl, 1'b0, functAdd, 1'b1, 4'd3, 4'd8, 12'h003));  // Carry and overflow
      drain();
      issue(dp(condAl, 1'b0, functAnd, 1'b1, 4'd1, 4'd8, 12'h002));  // C and V kept
      drain();
      issue(dp(condAl, 1'b0, functOrr, 1'b1, 4'd3, 4'd8, 12'h001));
      drain();
   endtask

   task automatic conditionCodes();
      logic [31:0] setters [4];
      setters[0] = dp(condAl, 1'b0, functSub, 1'b1, 4'd1, 4'd8, 12'h001);  // Z and C
      setters[1] = dp(condAl, 1'b0, functSub, 1'b1, 4'd1, 4'd8, 12'h002);  // N only
      setters[2] = dp(condAl, 1'b0, functAdd, 1'b1, 4'd3, 4'd8, 12'h003);  // Z, C and V
      setters[3] = dp(condAl, 1'b0, functSub, 1'b1, 4'd2, 4'd8, 12'h001);  // C only
      for (int s = 0; s < 4; s++)
         for (int c = 0; c < 16; c++)
         begin
            issue(setters[s]);
            issue(dp(4'(c), 1'b1, functAdd, 1'b1, 4'd9, 4'd9, 12'h001));
            issue(dp(condAl, 1'b1, functOrr, 1'b0, 4'd9, 4'd9, 12'h000));  // Shows r9
            drain();   // Flags right after the conditional
         end
   endtask

   task automatic randomMix();
      logic [31:0] ins;
      logic [1:0]  pick;
      for (int i = 0; i < 300; i++)
      begin
         ins = randomBits(32);
         if (randomBits(3) != 0)
            ins[27:26] = opDataProc;   // Mostly data processing
         if (randomBits(2) != 0)
         begin
            pick = randomBits(2);
            ins[24:21] = pick == 0 ? functAdd : pick == 1 ? functSub :
                         pick == 2 ? functAnd : functOrr;
         end
         if (randomBits(1))
            ins[31:28] = condAl;
         issue(ins);
      end
      drain();
   endtask

   initial
   begin
      while (cycleCount <= 40 * issued + 200)
         @(posedge clk);
      $display("Timeout: results still pending after %0d cycles", cycleCount);
      $display("Errors: %0d value mismatches, %0d unexpected strobes",
               valueErrors, strayStrobes);
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      reset = 1'b1;
      instrValid = 1'b0;
      instr = 32'd0;
      cycleCount = 0;
      issued = 0;
      valueErrors = 0;
      strayStrobes = 0;
      lfsrState = 16'd76;
      modelFlags = 4'b0000;
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      idleAfterReset();
      loadRegisters();
      forwardChain();
      flagCases();
      conditionCodes();
      randomMix();
      $display("Errors: %0d value mismatches, %0d unexpected strobes",
               valueErrors, strayStrobes);
      if (valueErrors == 0 && strayStrobes == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule
